//--- design/backEnd_settings.svh
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// Width of a data word, the PC and every datapath register.
`define DATA_WIDTH 16

// Eight architectural registers.
`define REG_SEL_WIDTH 3

// Data memory size in 16-bit words.
`define MEM_DEPTH 256

`endif

//--- design/exMemReg.sv
`timescale 1ns/10ps

`include "backEnd_settings.svh"

module exMemReg (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [pipePkg::CTRL_WIDTH-1:0] exCtrl,
	input  logic [`DATA_WIDTH-1:0]         exPcAdd2,
	input  logic [`DATA_WIDTH-1:0]         exStoreData,
	input  logic [`DATA_WIDTH-1:0]         exAluResult,
	input  logic                           exMsb,
	input  logic                           exZero,
	input  logic [`DATA_WIDTH-1:0]         exPcImmAdd,
	input  logic [`REG_SEL_WIDTH-1:0]      exWriteRegSel,
	input  logic                           exIllegal,
	output logic [pipePkg::CTRL_WIDTH-1:0] memCtrl,
	output logic [`DATA_WIDTH-1:0]         memPcAdd2,
	output logic [`DATA_WIDTH-1:0]         memStoreData,
	output logic [`DATA_WIDTH-1:0]         memAluResult,
	output logic                           memMsb,
	output logic                           memZero,
	output logic [`DATA_WIDTH-1:0]         memPcImmAdd,
	output logic [`REG_SEL_WIDTH-1:0]      memWriteRegSel,
	output logic                           memIllegal,
	output logic                           resetDelayed
);

	// A new instruction is captured on every edge.
	always_ff @(posedge clk) begin
		if (reset) begin
			memCtrl <= '0;
			memPcAdd2 <= '0;
			memStoreData <= '0;
			memAluResult <= '0;
			memMsb <= 1'b0;
			memZero <= 1'b0;
			memPcImmAdd <= '0;
			memWriteRegSel <= '0;
			memIllegal <= 1'b0;
		end else begin
			memCtrl <= exCtrl;
			memPcAdd2 <= exPcAdd2;
			memStoreData <= exStoreData;
			memAluResult <= exAluResult;
			memMsb <= exMsb;
			memZero <= exZero;
			memPcImmAdd <= exPcImmAdd;
			memWriteRegSel <= exWriteRegSel;
			memIllegal <= exIllegal;
		end
	end

	// One cycle copy of reset. Downstream errors are masked while it is high.
	always_ff @(posedge clk) begin
		resetDelayed <= reset;
	end

endmodule

//--- design/executeBackEnd.sv
`timescale 1ns/10ps

`include "backEnd_settings.svh"

module executeBackEnd (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [pipePkg::CTRL_WIDTH-1:0] ctrl,
	input  logic [`DATA_WIDTH-1:0]         pcAdd2,
	input  logic [`DATA_WIDTH-1:0]         operandA,
	input  logic [`DATA_WIDTH-1:0]         operandB,
	input  logic [`DATA_WIDTH-1:0]         immediate,
	input  logic [`REG_SEL_WIDTH-1:0]      writeRegSel,
	output logic                           branchTaken,
	output logic [`DATA_WIDTH-1:0]         branchTarget,
	output logic                           writeEnable,
	output logic [`REG_SEL_WIDTH-1:0]      writeReg,
	output logic [`DATA_WIDTH-1:0]         writeData,
	output logic                           halted,
	output logic                           err
);

	logic [`DATA_WIDTH-1:0] aluResult;
	logic msb;
	logic zero;
	logic [`DATA_WIDTH-1:0] pcImmAdd;
	logic illegalOp;

	logic [pipePkg::CTRL_WIDTH-1:0] memCtrl;
	logic [`DATA_WIDTH-1:0] memPcAdd2;
	logic [`DATA_WIDTH-1:0] memStoreData;
	logic [`DATA_WIDTH-1:0] memAluResult;
	logic memMsb;
	logic memZero;
	logic [`DATA_WIDTH-1:0] memPcImmAdd;
	logic [`REG_SEL_WIDTH-1:0] memWriteRegSel;
	logic memIllegal;
	logic resetDelayed;

	logic [`DATA_WIDTH-1:0] loadData;
	logic memError;

	executeStage executeStage_i (.ctrl, .pcAdd2, .operandA, .operandB, .immediate,
		.aluResult, .msb, .zero, .pcImmAdd, .illegalOp);

	// Operand B doubles as the store data.
	exMemReg exMemReg_i (.clk, .reset, .exCtrl(ctrl), .exPcAdd2(pcAdd2),
		.exStoreData(operandB), .exAluResult(aluResult), .exMsb(msb), .exZero(zero),
		.exPcImmAdd(pcImmAdd), .exWriteRegSel(writeRegSel), .exIllegal(illegalOp),
		.memCtrl, .memPcAdd2, .memStoreData, .memAluResult, .memMsb, .memZero,
		.memPcImmAdd, .memWriteRegSel, .memIllegal, .resetDelayed);

	memoryStage memoryStage_i (.clk, .memCtrl, .memStoreData, .memAluResult, .memMsb,
		.memZero, .memPcImmAdd, .branchTaken, .branchTarget, .loadData, .memError);

	writebackStage writebackStage_i (.clk, .reset, .resetDelayed, .memCtrl, .memPcAdd2,
		.memAluResult, .loadData, .memWriteRegSel, .memIllegal, .memError,
		.writeEnable, .writeReg, .writeData, .halted, .err);

endmodule

//--- design/executeStage.sv
`timescale 1ns/10ps

`include "backEnd_settings.svh"

module executeStage (
	input  logic [pipePkg::CTRL_WIDTH-1:0] ctrl,
	input  logic [`DATA_WIDTH-1:0]         pcAdd2,
	input  logic [`DATA_WIDTH-1:0]         operandA,
	input  logic [`DATA_WIDTH-1:0]         operandB,
	input  logic [`DATA_WIDTH-1:0]         immediate,
	output logic [`DATA_WIDTH-1:0]         aluResult,
	output logic                           msb,
	output logic                           zero,
	output logic [`DATA_WIDTH-1:0]         pcImmAdd,
	output logic                           illegalOp
);

	import isaPkg::*;
	import pipePkg::*;

	localparam int SHAMT_WIDTH = $clog2(`DATA_WIDTH);

	aluOp_e aluOp;
	logic [`DATA_WIDTH-1:0] bOperand;
	logic [SHAMT_WIDTH-1:0] shamt;

	assign aluOp = aluOp_e'(ctrl[ALU_OP_LSB +: $bits(aluOp_e)]);

	// The immediate replaces the second operand for the two immediate forms.
	assign bOperand = (aluOp == PASSB || aluOp == SLBI) ? immediate : operandB;
	assign shamt = bOperand[SHAMT_WIDTH-1:0];

	always_comb begin
		illegalOp = 1'b0;
		case (aluOp)
			ADD:     aluResult = operandA + bOperand;
			SUB:     aluResult = operandA - bOperand;
			AND:     aluResult = operandA & bOperand;
			OR:      aluResult = operandA | bOperand;
			XOR:     aluResult = operandA ^ bOperand;
			SLL:     aluResult = operandA << shamt;
			SRL:     aluResult = operandA >> shamt;
			SRA:     aluResult = $signed(operandA) >>> shamt;
			PASSB:   aluResult = bOperand;
			SLBI:    aluResult = (operandA << 8) | {8'b0, bOperand[7:0]};
			default: begin
				aluResult = '0;
				illegalOp = 1'b1;
			end
		endcase
	end

	assign msb = aluResult[`DATA_WIDTH-1];
	assign zero = (aluResult == '0);

	// Branch target is relative to the already incremented PC.
	assign pcImmAdd = pcAdd2 + immediate;

endmodule

//--- design/isaPkg.sv
package isaPkg;

	// ALU operations. Encodings 10 through 15 are undefined.
	typedef enum logic [3:0] {
		ADD   = 4'd0,
		SUB   = 4'd1,
		AND   = 4'd2,
		OR    = 4'd3,
		XOR   = 4'd4,
		SLL   = 4'd5,
		SRL   = 4'd6,
		SRA   = 4'd7,
		PASSB = 4'd8,
		SLBI  = 4'd9
	} aluOp_e;

	// Data memory operations. The spare encoding does nothing.
	typedef enum logic [1:0] {
		NONE  = 2'd0,
		LOAD  = 2'd1,
		STORE = 2'd2
	} memOp_e;

	// Branch conditions, tested against the sign and zero flags of the result.
	typedef enum logic [2:0] {
		NEVER  = 3'd0,
		EQZ    = 3'd1,
		NEZ    = 3'd2,
		LTZ    = 3'd3,
		GEZ    = 3'd4,
		ALWAYS = 3'd5
	} branchCond_e;

endpackage

//--- design/memoryStage.sv
`timescale 1ns/10ps

`include "backEnd_settings.svh"

module memoryStage (
	input  logic                           clk,
	input  logic [pipePkg::CTRL_WIDTH-1:0] memCtrl,
	input  logic [`DATA_WIDTH-1:0]         memStoreData,
	input  logic [`DATA_WIDTH-1:0]         memAluResult,
	input  logic                           memMsb,
	input  logic                           memZero,
	input  logic [`DATA_WIDTH-1:0]         memPcImmAdd,
	output logic                           branchTaken,
	output logic [`DATA_WIDTH-1:0]         branchTarget,
	output logic [`DATA_WIDTH-1:0]         loadData,
	output logic                           memError
);

	import isaPkg::*;
	import pipePkg::*;

	localparam int INDEX_WIDTH = $clog2(`MEM_DEPTH);

	memOp_e memOp;
	branchCond_e branchCond;
	logic [INDEX_WIDTH-1:0] wordIndex;
	logic misaligned;
	logic [`DATA_WIDTH-1:0] dataMem [`MEM_DEPTH] = '{default: '0};

	assign memOp = memOp_e'(memCtrl[MEM_OP_LSB +: $bits(memOp_e)]);
	assign branchCond = branchCond_e'(memCtrl[BRANCH_LSB +: $bits(branchCond_e)]);

	always_comb begin
		case (branchCond)
			NEVER:   branchTaken = 1'b0;
			EQZ:     branchTaken = memZero;
			NEZ:     branchTaken = ~memZero;
			LTZ:     branchTaken = memMsb;
			GEZ:     branchTaken = ~memMsb;
			ALWAYS:  branchTaken = 1'b1;
			default: branchTaken = 1'b0;
		endcase
	end

	assign branchTarget = memPcImmAdd;

	// The byte address becomes a word index that wraps at the end of memory.
	assign wordIndex = memAluResult[INDEX_WIDTH:1];

	assign misaligned = (memOp == LOAD || memOp == STORE) && memAluResult[0];
	assign memError = misaligned;

	// A misaligned store is dropped.
	always_ff @(posedge clk) begin
		if (memOp == STORE && !misaligned) begin
			dataMem[wordIndex] <= memStoreData;
		end
	end

	// The read is asynchronous so a load sees a store written on the previous edge.
	assign loadData = dataMem[wordIndex];

endmodule

//--- design/pipePkg.sv
package pipePkg;

	// Width of the decoded control word handed over by the decode stage.
	localparam int CTRL_WIDTH = 16;

	// Field positions inside the control word.
	// Bits 15:13 are reserved and ignored.
	localparam int ALU_OP_LSB = 0;
	localparam int MEM_OP_LSB = 4;
	localparam int BRANCH_LSB = 6;
	localparam int WB_SRC_LSB = 9;
	localparam int REG_WRITE_BIT = 11;
	localparam int HALT_BIT = 12;

	// Source of the value written back to the register file.
	typedef enum logic [1:0] {
		ALU  = 2'd0,
		MEM  = 2'd1,
		LINK = 2'd2
	} wbSource_e;

endpackage

//--- design/writebackStage.sv
`timescale 1ns/10ps

`include "backEnd_settings.svh"

module writebackStage (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           resetDelayed,
	input  logic [pipePkg::CTRL_WIDTH-1:0] memCtrl,
	input  logic [`DATA_WIDTH-1:0]         memPcAdd2,
	input  logic [`DATA_WIDTH-1:0]         memAluResult,
	input  logic [`DATA_WIDTH-1:0]         loadData,
	input  logic [`REG_SEL_WIDTH-1:0]      memWriteRegSel,
	input  logic                           memIllegal,
	input  logic                           memError,
	output logic                           writeEnable,
	output logic [`REG_SEL_WIDTH-1:0]      writeReg,
	output logic [`DATA_WIDTH-1:0]         writeData,
	output logic                           halted,
	output logic                           err
);

	import pipePkg::*;

	wbSource_e wbSrc;
	logic [`DATA_WIDTH-1:0] wbAluResult;
	logic [`DATA_WIDTH-1:0] wbLoadData;
	logic [`DATA_WIDTH-1:0] wbPcAdd2;

	always_ff @(posedge clk) begin
		wbAluResult <= memAluResult;
		wbLoadData <= loadData;
		wbPcAdd2 <= memPcAdd2;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wbSrc <= ALU;
			writeEnable <= 1'b0;
			writeReg <= '0;
			halted <= 1'b0;
			err <= 1'b0;
		end else begin
			wbSrc <= wbSource_e'(memCtrl[WB_SRC_LSB +: $bits(wbSource_e)]);
			writeEnable <= memCtrl[REG_WRITE_BIT];
			writeReg <= memWriteRegSel;
			// Halt is sticky until the next reset.
			halted <= halted | memCtrl[HALT_BIT];
			err <= (memIllegal | memError) & ~resetDelayed;
		end
	end

	always_comb begin
		case (wbSrc)
			MEM:     writeData = wbLoadData;
			LINK:    writeData = wbPcAdd2;
			default: writeData = wbAluResult;
		endcase
	end

endmodule

//--- project.f
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/executeStage.sv
design/exMemReg.sv
design/memoryStage.sv
design/writebackStage.sv
design/executeBackEnd.sv
testbench/backEnd_chk.sv
testbench/backEndTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module backEndTb -f project.f

output=$(./obj_dir/VbackEndTb || true)
echo "$output"

if echo "$output" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1

//--- testbench/backEndTb.sv
`timescale 1ns/10ps

`include "backEnd_settings.svh"

module backEndTb;

	import isaPkg::*;
	import pipePkg::*;

	localparam int HALT_TIMEOUT = 20;

	typedef logic [`DATA_WIDTH-1:0] word_t;

	// One instruction as the model sees it on its way down the pipeline.
	typedef struct packed {
		word_t pcAdd2;
		word_t aluResult;
		word_t storeData;
		word_t target;
		word_t wbData;
		logic [`REG_SEL_WIDTH-1:0] writeReg;
		logic [1:0] memOp;
		logic [1:0] wbSrc;
		logic taken;
		logic regWrite;
		logic halt;
		logic fault;
	} instr_t;

	logic clk = 1'b0;
	logic reset;
	logic [CTRL_WIDTH-1:0] ctrl;
	word_t pcAdd2;
	word_t operandA;
	word_t operandB;
	word_t immediate;
	logic [`REG_SEL_WIDTH-1:0] writeRegSel;
	logic branchTaken;
	word_t branchTarget;
	logic writeEnable;
	logic [`REG_SEL_WIDTH-1:0] writeReg;
	word_t writeData;
	logic halted;
	logic err;

	logic [31:0] lfsrState;
	word_t modelMem [`MEM_DEPTH];
	instr_t pipe [$];
	logic expectHalted;
	logic timedOut;
	int errorCount;
	int checkCount;
	string testName;

	executeBackEnd executeBackEnd_i (.clk, .reset, .ctrl, .pcAdd2, .operandA, .operandB,
		.immediate, .writeRegSel, .branchTaken, .branchTarget, .writeEnable, .writeReg,
		.writeData, .halted, .err);

	always #5 clk = ~clk;

	function automatic logic [31:0] nextLfsr(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit taken.
	task automatic drawBits(input int count, output word_t value);
		int i;
		value = '0;
		for (i = 0; i < count; i++) begin
			lfsrState = nextLfsr(lfsrState);
			value = {value[`DATA_WIDTH-2:0], lfsrState[0]};
		end
	endtask

	function automatic word_t modelAlu(input logic [3:0] op, input word_t a, input word_t b,
		input word_t imm);
		logic [2*`DATA_WIDTH-1:0] extended;
		extended = {{`DATA_WIDTH{a[`DATA_WIDTH-1]}}, a} >> b[3:0];
		case (op)
			ADD:     return a + b;
			SUB:     return a + ~b + 16'd1;
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			SLL:     return a << b[3:0];
			SRL:     return a >> b[3:0];
			SRA:     return extended[`DATA_WIDTH-1:0];
			PASSB:   return imm;
			SLBI:    return {a[7:0], imm[7:0]};
			default: return '0;
		endcase
	endfunction

	function automatic logic branchDecision(input logic [2:0] cond, input word_t result);
		logic isZero;
		logic isNeg;
		isZero = (result == '0);
		isNeg = result[`DATA_WIDTH-1];
		case (cond)
			EQZ:     return isZero;
			NEZ:     return !isZero;
			LTZ:     return isNeg;
			GEZ:     return !isNeg;
			ALWAYS:  return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic checkValue(input string name, input word_t expected, input word_t actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("Error: %s %s expected %h actual %h", testName, name, expected, actual);
		end
	endtask

	task automatic driveIdle;
		ctrl = '0;
		pcAdd2 = '0;
		operandA = '0;
		operandB = '0;
		immediate = '0;
		writeRegSel = '0;
	endtask

	task automatic issueRandom;
		word_t bits;
		word_t a;
		word_t b;
		word_t imm;
		word_t pc;
		logic [2:0] kind;
		logic [3:0] op;
		logic [1:0] mem;
		logic [1:0] src;
		logic [CTRL_WIDTH-1:0] ctrlWord;
		instr_t entry;
		drawBits(3, bits);
		kind = bits[2:0];
		drawBits(16, a);
		drawBits(16, b);
		drawBits(16, imm);
		drawBits(15, bits);
		pc = {bits[14:0], 1'b0};
		drawBits(13, bits);
		ctrlWord = bits;
		op = ctrlWord[ALU_OP_LSB +: 4];
		src = ctrlWord[WB_SRC_LSB +: 2];
		// Most undefined ALU encodings are folded back onto legal ones.
		if (op > 4'd9) begin
			drawBits(2, bits);
			if (bits[1:0] != 2'd0) begin
				op = op - 4'd6;
			end
		end
		drawBits(5, bits);
		ctrlWord[HALT_BIT] = (bits[4:0] == 5'h1f);
		mem = NONE;
		if (kind < 3'd3) begin
			// Addresses stay in a small window of words so loads often hit earlier stores.
			mem = (kind == 3'd2) ? LOAD : STORE;
			op = PASSB;
			drawBits(6, bits);
			imm = {12'd0, bits[2:0], (bits[5:3] == 3'd0)};
			if (mem == LOAD) begin
				src = MEM;
				ctrlWord[REG_WRITE_BIT] = 1'b1;
			end
		end
		ctrlWord[ALU_OP_LSB +: 4] = op;
		ctrlWord[MEM_OP_LSB +: 2] = mem;
		ctrlWord[WB_SRC_LSB +: 2] = src;
		drawBits(6, bits);
		ctrlWord[15:13] = bits[2:0];
		entry.aluResult = modelAlu(op, a, b, imm);
		entry.fault = (op > 4'd9) || ((mem == LOAD || mem == STORE) && entry.aluResult[0]);
		entry.taken = branchDecision(ctrlWord[BRANCH_LSB +: 3], entry.aluResult);
		entry.target = pc + imm;
		entry.storeData = b;
		entry.pcAdd2 = pc;
		entry.wbData = '0;
		entry.writeReg = bits[5:3];
		entry.memOp = mem;
		entry.wbSrc = src;
		entry.regWrite = ctrlWord[REG_WRITE_BIT];
		entry.halt = ctrlWord[HALT_BIT];
		pipe.push_back(entry);
		ctrl = ctrlWord;
		pcAdd2 = pc;
		operandA = a;
		operandB = b;
		immediate = imm;
		writeRegSel = bits[5:3];
	endtask

	// Checks the write-back stage, then the memory stage, against the model.
	task automatic retireAndResolve;
		instr_t retired;
		instr_t entry;
		int idx;
		if (pipe.size() == 2) begin
			retired = pipe.pop_front();
			expectHalted = expectHalted | retired.halt;
			checkValue("writeEnable", word_t'(retired.regWrite), word_t'(writeEnable));
			checkValue("writeReg", word_t'(retired.writeReg), word_t'(writeReg));
			checkValue("writeData", retired.wbData, writeData);
			checkValue("halted", word_t'(expectHalted), word_t'(halted));
			checkValue("err", word_t'(retired.fault), word_t'(err));
		end
		if (pipe.size() == 1) begin
			entry = pipe[0];
			checkValue("branchTaken", word_t'(entry.taken), word_t'(branchTaken));
			checkValue("branchTarget", entry.target, branchTarget);
			idx = int'(entry.aluResult[`DATA_WIDTH-1:1]) % `MEM_DEPTH;
			case (entry.wbSrc)
				MEM:     entry.wbData = modelMem[idx];
				LINK:    entry.wbData = entry.pcAdd2;
				default: entry.wbData = entry.aluResult;
			endcase
			// The DUT writes this store on the coming rising edge.
			if (entry.memOp == STORE && !entry.aluResult[0]) begin
				modelMem[idx] = entry.storeData;
			end
			pipe[0] = entry;
		end
	endtask

	task automatic expectIdle;
		int i;
		for (i = 0; i < 2; i++) begin
			if (i > 0) begin
				@(negedge clk);
			end
			checkValue("idle branchTaken", '0, word_t'(branchTaken));
			checkValue("idle writeEnable", '0, word_t'(writeEnable));
			checkValue("idle halted", '0, word_t'(halted));
			checkValue("idle err", '0, word_t'(err));
		end
	endtask

	task automatic applyReset;
		reset = 1'b1;
		// A random instruction sits on the inputs while reset is high.
		issueRandom;
		pipe.delete();
		expectHalted = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		driveIdle;
		expectIdle;
	endtask

	task automatic runRandom(input int count);
		repeat (count) begin
			@(negedge clk);
			retireAndResolve;
			issueRandom;
		end
	endtask

	task automatic waitForHalt;
		int cycles;
		logic [CTRL_WIDTH-1:0] haltCtrl;
		haltCtrl = '0;
		haltCtrl[HALT_BIT] = 1'b1;
		ctrl = haltCtrl;
		cycles = 0;
		while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			driveIdle;
			cycles++;
		end
		if (halted !== 1'b1) begin
			errorCount++;
			timedOut = 1'b1;
			$display("Timeout: halted did not rise after a halting instruction");
		end else begin
			checkValue("haltLatency", word_t'(2), word_t'(cycles));
			repeat (4) begin
				@(negedge clk);
				checkValue("halted", word_t'(1), word_t'(halted));
			end
		end
	endtask

	initial begin
		int i;
		lfsrState = 32'd66310;
		errorCount = 0;
		checkCount = 0;
		timedOut = 1'b0;
		for (i = 0; i < `MEM_DEPTH; i++) begin
			modelMem[i] = '0;
		end
		testName = "reset";
		applyReset;
		testName = "random";
		runRandom(600);
		testName = "halt";
		applyReset;
		waitForHalt;
		if (!timedOut) begin
			testName = "afterHalt";
			applyReset;
			runRandom(600);
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- testbench/backEnd_chk.sv
`timescale 1ns/10ps

module backEndChk (
	input logic                           clk,
	input logic                           reset,
	input logic                           resetDelayed,
	input logic [pipePkg::CTRL_WIDTH-1:0] memCtrl,
	input logic                           writeEnable,
	input logic                           halted,
	input logic                           err
);

	// A reset edge empties the EX/MEM register and the write-back outputs.
	clearAfterReset: assert property (@(posedge clk)
		reset |=> (memCtrl == '0 && !writeEnable && !halted && !err))
		else $error("Pipeline outputs are not clear one cycle after reset");

	delayedResetHigh: assert property (@(posedge clk) reset |=> resetDelayed)
		else $error("resetDelayed did not rise one cycle after reset");

	delayedResetLow: assert property (@(posedge clk) !reset |=> !resetDelayed)
		else $error("resetDelayed did not fall one cycle after reset");

	// Halt is sticky until the next reset.
	haltSticky: assert property (@(posedge clk) (halted && !reset) |=> halted)
		else $error("halted fell without a reset");

endmodule

bind writebackStage backEndChk backEndChk_i (.clk, .reset, .resetDelayed, .memCtrl,
	.writeEnable, .halted, .err);
